// ==== files.f ====
src/arm_isa_pkg.sv
src/control_pkg.sv
src/instr_decoder.sv
src/control_unit.sv
src/cpu_control_top.sv
tb/control_props.sv
tb/control_tb.sv

// ==== Makefile ====
SOURCES := files.f $(wildcard src/*.sv) $(wildcard tb/*.sv)

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
obj_dir/Vcontrol_tb: $(SOURCES)
	verilator --binary --assert -j 0 --top-module control_tb -f files.f -o Vcontrol_tb

run: obj_dir/Vcontrol_tb
	./obj_dir/Vcontrol_tb > sim.log 2>&1; status=$$?; cat sim.log; \
	if [ $$status -ne 0 ] || grep -q "SIMULATION FAILED" sim.log; then \
		exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log

// ==== tb/control_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module control_tb
  import arm_isa_pkg::*;
  import control_pkg::*;
();

  localparam int num_blocks = 8;
  localparam int block_len = 50;
  localparam int num_instr = num_blocks * block_len;
  localparam int clk_period = 10;
  // Loads take 3 cycles at most, with a margin for reset
  localparam int watchdog_ns = num_instr * 3 * clk_period + 100 * clk_period;

  logic        clk;
  logic        reset;
  logic [31:0] instr_data;
  logic [3:0]  flags;
  logic        flush_req;
  control_t    control;

  logic [31:0] next_word;
  int          checks;
  int          errors;
  int          tests;
  int          failed_tests;

  cpu_control_top dut (
    .clk        (clk),
    .reset      (reset),
    .instr_data (instr_data),
    .flags      (flags),
    .flush_req  (flush_req),
    .control    (control)
  );

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  initial begin
    #(watchdog_ns);
    $display("Timeout: the run did not finish within %0d ns", watchdog_ns);
    $display("SIMULATION FAILED");
    $finish;
  end

  // ========================================
  // Reference model
  // ========================================

  function automatic instr_class_t classify(logic [31:0] w);
    case (w[27:25])
      3'b000: return w[4] ? instr_dataproc_reg_reg : instr_dataproc_reg_imm;
      3'b001: return instr_dataproc_imm;
      3'b010: return w[20] ? instr_load : instr_store;
      3'b011: begin
        if (w[4]) begin
          return instr_undef;
        end
        return w[20] ? instr_load : instr_store;
      end
      default: return instr_undef;
    endcase
  endfunction

  // Odd codes are the inverse of the even code below them
  function automatic logic condition_holds(logic [3:0] cond, logic [3:0] nzcv);
    logic n;
    logic z;
    logic c;
    logic v;
    logic base;
    {n, z, c, v} = nzcv;
    case (cond[3:1])
      3'd0: base = z;
      3'd1: base = c;
      3'd2: base = n;
      3'd3: base = v;
      3'd4: base = c && !z;
      3'd5: base = (n == v);
      3'd6: base = !z && (n == v);
      default: base = 1'b1;
    endcase
    return cond[0] ? !base : base;
  endfunction

  function automatic int latency_of(instr_class_t cls);
    case (cls)
      instr_dataproc_reg_reg, instr_store: return 2;
      instr_load: return 3;
      default: return 1;
    endcase
  endfunction

  function automatic control_t with_fetch_bits(control_t c);
    c.pipeline_advance      = 1'b1;
    c.addr_bus_src          = addr_pc;
    c.memory_read_en        = 1'b1;
    c.memory_latch_ir       = 1'b1;
    c.incrementer_writeback = 1'b1;
    return c;
  endfunction

  function automatic control_t refetch_step();
    control_t c;
    c = '0;
    c.addr_bus_src          = addr_incr;
    c.memory_read_en        = 1'b1;
    c.memory_latch_ir       = 1'b1;
    c.incrementer_writeback = 1'b1;
    return c;
  endfunction

  function automatic control_t shifted_rm(control_t c, logic [31:0] w);
    c.b_bus_source  = b_reg_rm;
    c.shift_type    = shift_t'(w[6:5]);
    c.shift_amount  = w[11:7];
    c.shift_use_rrx = (w[6:5] == 2'b11) && (w[11:7] == 5'd0);
    return c;
  endfunction

  // Opcodes 8 to 11 are the compares and tests
  function automatic control_t dp_result(control_t c, logic [31:0] w, logic pass);
    c.alu_op = alu_op_t'(w[24:21]);
    if (pass) begin
      c.alu_writeback = (w[24:23] == 2'b10) ? wb_none : wb_rd;
      c.alu_set_flags = w[20];
    end
    return c;
  endfunction

  function automatic control_t expected_control(logic [31:0] w, instr_class_t cls,
                                                logic pass, int cyc, logic flushed);
    control_t e;
    alu_op_t  ls_op;
    logic     base_wb;
    e = '0;
    ls_op = w[23] ? alu_add : alu_sub;
    base_wb = pass && (!w[24] || w[21]);
    if (flushed) begin
      return (cyc == 0) ? refetch_step() : with_fetch_bits(e);
    end
    case (cls)
      instr_dataproc_imm: begin
        e.b_bus_source = b_imm;
        e.b_bus_imm    = {4'd0, w[7:0]};
        e.shift_type   = shift_ror;
        e.shift_amount = {w[11:8], 1'b0};
        e = dp_result(e, w, pass);
      end
      instr_dataproc_reg_imm: begin
        e = shifted_rm(e, w);
        e = dp_result(e, w, pass);
      end
      instr_dataproc_reg_reg: begin
        if (cyc == 0) begin
          e.b_bus_source    = b_reg_rs;
          e.shift_latch_amt = 1'b1;
        end else begin
          e.b_bus_source    = b_reg_rm;
          e.shift_type      = shift_t'(w[6:5]);
          e.shift_use_latch = 1'b1;
          e = dp_result(e, w, pass);
        end
      end
      instr_load, instr_store: begin
        if (cyc == 0) begin
          // Address through the ALU while the next word is prefetched
          e.addr_bus_src          = addr_alu;
          e.memory_read_en        = 1'b1;
          e.memory_latch_ir       = 1'b1;
          e.incrementer_writeback = 1'b1;
          e.alu_op                = ls_op;
          if (w[25]) begin
            e = shifted_rm(e, w);
          end else begin
            e.b_bus_source = b_imm;
            e.b_bus_imm    = w[11:0];
          end
          e.alu_latch_op_b   = w[24] ? w[21] : 1'b1;
          e.alu_disable_op_b = !w[24];
        end else if (cls == instr_store || cyc == 1) begin
          e.alu_op               = ls_op;
          e.memory_byte_transfer = w[22];
          if (cls == instr_store) begin
            e.b_bus_source    = b_reg_rd;
            e.memory_write_en = pass;
          end else begin
            e.memory_read_en = 1'b1;
          end
          if (base_wb) begin
            e.alu_use_op_b_latch = 1'b1;
            e.alu_writeback      = wb_rn;
          end
        end else begin
          e.b_bus_source         = b_read_data;
          e.alu_op               = alu_mov;
          e.memory_byte_transfer = w[22];
          e.alu_writeback        = pass ? wb_rd : wb_none;
        end
      end
      default: ;
    endcase
    if (cyc == latency_of(cls) - 1) begin
      e = with_fetch_bits(e);
    end
    return e;
  endfunction

  // ========================================
  // Stimulus and checks
  // ========================================

  // About 5 percent undefined words with the rest spread over the five classes
  function automatic logic [31:0] random_word();
    logic [31:0] w;
    int          pick;
    w = $urandom;
    pick = int'($urandom_range(99));
    pick = (pick < 5) ? 5 : int'($urandom_range(4));
    case (pick)
      0: w[27:25] = 3'b001;
      1: begin
        w[27:25] = 3'b000;
        w[4]     = 1'b0;
      end
      2: begin
        w[27:25] = 3'b000;
        w[4]     = 1'b1;
      end
      3, 4: begin
        w[27:26] = 2'b01;
        w[20]    = (pick == 3);
        if (w[25]) begin
          w[4] = 1'b0;
        end
      end
      default: begin
        if ($urandom_range(4) == 0) begin
          w[27:25] = 3'b011;
          w[4]     = 1'b1;
        end else begin
          w[27] = 1'b1;
        end
      end
    endcase
    // Ror by zero often enough to reach rrx
    if (pick != 0 && pick != 5 && $urandom_range(3) == 0) begin
      w[11:5] = 7'b0000011;
    end
    return w;
  endfunction

  task automatic check_control(input control_t expected, input string what);
    checks++;
    assert (control == expected) else begin
      errors++;
      $display("MISMATCH %0t: %s, control %h, expected %h", $time, what, control, expected);
    end
  endtask

  task automatic report_test(input string name, input int start_errors);
    tests++;
    if (errors != start_errors) begin
      failed_tests++;
      $display("%s: %0d errors", name, errors - start_errors);
    end else begin
      $display("%s: ok", name);
    end
  endtask

  task automatic run_reset_flush();
    int start_errors;
    start_errors = errors;
    repeat (3) begin
      @(negedge clk);
      #1;
      check_control('0, "control during reset");
    end
    @(negedge clk);
    reset = 1'b0;
    #1;
    check_control('0, "flush step 3");
    @(negedge clk);
    #1;
    check_control(refetch_step(), "flush step 2");
    @(negedge clk);
    #1;
    check_control(with_fetch_bits('0), "first fetch");
    // The cleared IR decodes as undefined until the first word is latched
    checks++;
    assert (dut.decoded.iclass == instr_undef) else begin
      errors++;
      $display("MISMATCH %0t: cleared IR decoded as class %0d, expected undef",
               $time, dut.decoded.iclass);
    end
    report_test("reset flush", start_errors);
  endtask

  // Starts in the advance cycle of the previous instruction
  task automatic run_instruction(input logic do_flush);
    logic [31:0]  word;
    logic [3:0]   nzcv;
    instr_class_t cls;
    logic         pass;
    int           latency;
    int           cyc;
    logic         advanced;
    @(negedge clk);
    word = next_word;
    next_word = random_word();
    instr_data = next_word;
    nzcv = 4'($urandom);
    flags = nzcv;
    flush_req = do_flush;
    cls = classify(word);
    pass = condition_holds(word[31:28], nzcv);
    latency = do_flush ? 2 : latency_of(cls);
    cyc = 0;
    advanced = 1'b0;
    while (!advanced && cyc < 4) begin
      if (cyc > 0) begin
        @(negedge clk);
        flush_req = 1'b0;
      end
      #1;
      if (cyc == 0) begin
        checks++;
        assert (dut.decoded.iclass == cls && dut.decoded.cond_pass == pass) else begin
          errors++;
          $display("MISMATCH %0t: word %h decoded as class %0d pass %b, expected %0d pass %b",
                   $time, word, dut.decoded.iclass, dut.decoded.cond_pass, cls, pass);
        end
      end
      check_control(expected_control(word, cls, pass, cyc, do_flush),
                    $sformatf("%s word %h cycle %0d", cls.name(), word, cyc));
      advanced = control.pipeline_advance;
      cyc++;
    end
    checks++;
    assert (cyc == latency) else begin
      errors++;
      $display("MISMATCH %0t: word %h took %0d cycles, expected %0d", $time, word, cyc, latency);
    end
  endtask

  task automatic run_block(input int idx);
    int   start_errors;
    int   flushes;
    logic do_flush;
    start_errors = errors;
    flushes = 0;
    for (int i = 0; i < block_len; i++) begin
      do_flush = ($urandom_range(15) == 0);
      if (do_flush) begin
        flushes++;
      end
      run_instruction(do_flush);
    end
    report_test($sformatf("random block %0d, %0d instructions, %0d flushed",
                          idx, block_len, flushes), start_errors);
  endtask

  initial begin
    void'($urandom(32'h3830_5f1e));
    checks = 0;
    errors = 0;
    tests = 0;
    failed_tests = 0;
    reset = 1'b1;
    flags = 4'h0;
    flush_req = 1'b0;
    next_word = random_word();
    instr_data = next_word;
    run_reset_flush();
    for (int b = 0; b < num_blocks; b++) begin
      run_block(b + 1);
    end
    $display("tests %0d, failed %0d, checks %0d, errors %0d",
             tests, failed_tests, checks, errors);
    if (errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== tb/control_props.sv ====
`timescale 1ns/10ps
`default_nettype none

module control_props
  import arm_isa_pkg::*;
  import control_pkg::*;
(
  input logic           clk,
  input logic           reset,
  input decoded_instr_t decoded,
  input control_t       control
);

  logic [2:0] since_advance;
  control_t   without_addr;

  // Cycles since the last advance, saturating
  always_ff @(posedge clk) begin
    if (reset) begin
      since_advance <= '0;
    end else if (control.pipeline_advance) begin
      since_advance <= '0;
    end else if (since_advance != 3'd7) begin
      since_advance <= since_advance + 3'd1;
    end
  end

  always_comb begin
    without_addr = control;
    without_addr.addr_bus_src = addr_pc;
  end

  // ========================================
  // Properties
  // ========================================

  advance_gap: assert property (@(posedge clk) disable iff (reset) since_advance < 3'd3)
    else $error("no pipeline advance within three cycles");

  write_source: assert property (@(posedge clk) disable iff (reset)
    control.memory_write_en |-> control.b_bus_source == b_reg_rd)
    else $error("memory write without Rd on the B bus");

  // Failed condition suppresses writeback, load data cycle aside
  wb_gated: assert property (@(posedge clk) disable iff (reset)
    (!decoded.cond_pass && !(decoded.iclass == instr_load && control.pipeline_advance))
      |-> control.alu_writeback == wb_none)
    else $error("register writeback with a failed condition");

  reset_quiet: assert property (@(posedge clk) (reset && $past(reset)) |-> without_addr == '0)
    else $error("control word active during reset");

endmodule

bind control_unit control_props u_props (
  .clk     (clk),
  .reset   (reset),
  .decoded (decoded),
  .control (control)
);

`default_nettype wire

// ==== src/cpu_control_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module cpu_control_top
  import arm_isa_pkg::*;
  import control_pkg::*;
(
  input  logic        clk,
  input  logic        reset,
  input  logic [31:0] instr_data,
  input  logic [3:0]  flags,
  input  logic        flush_req,
  output control_t    control
);

  // ========================================
  // Decoder to sequencer
  // ========================================

  decoded_instr_t decoded;

  // IR loads on the sequencer's advance
  instr_decoder u_decoder (
    .clk              (clk),
    .reset            (reset),
    .instr_data       (instr_data),
    .flags            (flags),
    .pipeline_advance (control.pipeline_advance),
    .decoded          (decoded)
  );

  control_unit u_control (
    .clk       (clk),
    .reset     (reset),
    .decoded   (decoded),
    .flush_req (flush_req),
    .control   (control)
  );

endmodule

`default_nettype wire

// ==== src/control_unit.sv ====
`timescale 1ns/10ps
`default_nettype none

module control_unit
  import arm_isa_pkg::*;
  import control_pkg::*;
(
  input  logic           clk,
  input  logic           reset,
  input  decoded_instr_t decoded,
  input  logic           flush_req,
  output control_t       control
);

  logic [flush_cnt_w-1:0] flush_cnt;
  logic [cycle_cnt_w-1:0] cycle;
  operand_field_u         f;
  alu_op_t                ls_op;
  logic                   ls_base_wb;

  // Final cycle of every instruction: fetch at PC and latch the next word
  function automatic control_t with_fetch(control_t c);
    control_t r;
    r = c;
    r.pipeline_advance      = 1'b1;
    r.addr_bus_src          = addr_pc;
    r.memory_read_en        = 1'b1;
    r.memory_latch_ir       = 1'b1;
    r.incrementer_writeback = 1'b1;
    return r;
  endfunction

  // Rm through the shifter by an immediate amount, ror #0 meaning rrx
  function automatic control_t with_shifted_rm(control_t c, dp_reg_imm_t sh);
    control_t r;
    r = c;
    r.b_bus_source  = b_reg_rm;
    r.shift_type    = sh.shift_type;
    r.shift_amount  = sh.shift_amount;
    r.shift_use_rrx = (sh.shift_type == shift_ror) && (sh.shift_amount == 5'd0);
    return r;
  endfunction

  // ALU result of a data-processing instruction
  function automatic control_t with_dp_result(control_t c, alu_op_t op, logic s, logic pass);
    control_t r;
    r = c;
    r.alu_op = op;
    if (pass) begin
      r.alu_writeback = alu_writeback_for(op);
      r.alu_set_flags = s;
    end
    return r;
  endfunction

  // Base register update from the latched offset
  function automatic control_t with_base_wb(control_t c, logic base_wb);
    control_t r;
    r = c;
    if (base_wb) begin
      r.alu_use_op_b_latch = 1'b1;
      r.alu_writeback      = wb_rn;
    end
    return r;
  endfunction

  assign f = decoded.field;
  assign ls_op = f.ls.u ? alu_add : alu_sub;
  // Post-indexed transfers always write the base back
  assign ls_base_wb = decoded.cond_pass && (!f.ls.p || f.ls.w);

  // ========================================
  // Flush and cycle counters
  // ========================================

  always_ff @(posedge clk) begin
    if (reset) begin
      flush_cnt <= flush_cnt_w'(reset_flush_len);
    end else if (flush_req) begin
      flush_cnt <= flush_cnt_w'(1);
    end else if (flush_cnt != '0) begin
      flush_cnt <= flush_cnt - 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      cycle <= '0;
    end else if (control.pipeline_advance) begin
      cycle <= '0;
    end else begin
      cycle <= cycle + 1'b1;
    end
  end

  // ========================================
  // Control word
  // ========================================

  always_comb begin
    control = '0;
    if (flush_cnt == flush_cnt_w'(reset_flush_len)) begin
      // Flush step 3, PC onto the address bus
      control.addr_bus_src = addr_pc;
    end else if (flush_cnt == flush_cnt_w'(2) || flush_req) begin
      // Flush step 2
      control.memory_read_en        = 1'b1;
      control.memory_latch_ir       = 1'b1;
      control.incrementer_writeback = 1'b1;
      control.addr_bus_src          = addr_incr;
    end else if (flush_cnt == flush_cnt_w'(1)) begin
      control = with_fetch(control);
    end else begin
      case (decoded.iclass)
        instr_dataproc_imm: begin
          control.b_bus_source = b_imm;
          control.b_bus_imm    = {4'd0, f.dp_imm.imm8};
          control.shift_type   = shift_ror;
          control.shift_amount = {f.dp_imm.rotate, 1'b0};
          control = with_dp_result(control, f.dp_imm.opcode, f.dp_imm.set_flags,
                                   decoded.cond_pass);
          control = with_fetch(control);
        end

        instr_dataproc_reg_imm: begin
          control = with_shifted_rm(control, f.dp_reg_imm);
          control = with_dp_result(control, f.dp_reg_imm.opcode, f.dp_reg_imm.set_flags,
                                   decoded.cond_pass);
          control = with_fetch(control);
        end

        instr_dataproc_reg_reg: begin
          if (cycle == '0) begin
            // Read Rs and hold the shift amount
            control.b_bus_source    = b_reg_rs;
            control.shift_latch_amt = 1'b1;
          end else begin
            control.b_bus_source    = b_reg_rm;
            control.shift_type      = f.dp_reg_reg.shift_type;
            control.shift_use_latch = 1'b1;
            control = with_dp_result(control, f.dp_reg_reg.opcode, f.dp_reg_reg.set_flags,
                                     decoded.cond_pass);
            control = with_fetch(control);
          end
        end

        instr_load, instr_store: begin
          if (cycle == '0) begin
            // Effective address from the ALU, prefetch at PC meanwhile
            control.addr_bus_src          = addr_alu;
            control.memory_read_en        = 1'b1;
            control.memory_latch_ir       = 1'b1;
            control.incrementer_writeback = 1'b1;
            control.alu_op                = ls_op;
            if (!decoded.ir[25]) begin
              control.b_bus_source = b_imm;
              control.b_bus_imm    = f.ls.offset;
              control.shift_type   = shift_lsl;
            end else begin
              control = with_shifted_rm(control, f.dp_reg_imm);
            end
            if (f.ls.p) begin
              control.alu_latch_op_b = f.ls.w;
            end else begin
              control.alu_disable_op_b = 1'b1;
              control.alu_latch_op_b   = 1'b1;
            end
          end else if (decoded.iclass == instr_store) begin
            control.b_bus_source         = b_reg_rd;
            control.alu_op               = ls_op;
            control.memory_write_en      = decoded.cond_pass;
            control.memory_byte_transfer = f.ls.b;
            control = with_base_wb(control, ls_base_wb);
            control = with_fetch(control);
          end else if (cycle == cycle_cnt_w'(1)) begin
            // Load data read at the effective address
            control.alu_op               = ls_op;
            control.memory_read_en       = 1'b1;
            control.memory_byte_transfer = f.ls.b;
            control.addr_bus_src         = addr_pc;
            control = with_base_wb(control, ls_base_wb);
          end else begin
            control.b_bus_source         = b_read_data;
            control.alu_op               = alu_mov;
            control.memory_byte_transfer = f.ls.b;
            if (decoded.cond_pass) begin
              control.alu_writeback = wb_rd;
            end
            control = with_fetch(control);
          end
        end

        // Undefined words retire as a plain fetch
        default: control = with_fetch(control);
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== src/instr_decoder.sv ====
`timescale 1ns/10ps
`default_nettype none

module instr_decoder
  import arm_isa_pkg::*;
(
  input  logic           clk,
  input  logic           reset,
  input  logic [31:0]    instr_data,
  input  logic [3:0]     flags,
  input  logic           pipeline_advance,
  output decoded_instr_t decoded
);

  logic [31:0]    ir;
  logic           ir_valid;
  operand_field_u field;
  cond_t          cond;
  instr_class_t   iclass;
  logic           cond_pass;
  logic           n;
  logic           z;
  logic           c;
  logic           v;

  // ========================================
  // Instruction register
  // ========================================

  // Nothing has been latched until the first advance after reset
  always_ff @(posedge clk) begin
    if (reset) begin
      ir       <= '0;
      ir_valid <= 1'b0;
    end else if (pipeline_advance) begin
      ir       <= instr_data;
      ir_valid <= 1'b1;
    end
  end

  assign field = ir[24:0];
  assign cond = cond_t'(ir[31:28]);
  assign {n, z, c, v} = flags;

  // ========================================
  // Class decode
  // ========================================

  always_comb begin
    iclass = instr_undef;
    if (ir_valid) begin
      case (ir[27:25])
        3'b000: begin
          // Bit 4 picks shift by register over shift by immediate
          if (field.dp_reg_imm.reg_shift) begin
            iclass = instr_dataproc_reg_reg;
          end else begin
            iclass = instr_dataproc_reg_imm;
          end
        end
        3'b001: iclass = instr_dataproc_imm;
        3'b010: iclass = field.ls.l ? instr_load : instr_store;
        3'b011: begin
          // Register offset; bit 4 set is outside the load/store space
          if (!field.dp_reg_imm.reg_shift) begin
            iclass = field.ls.l ? instr_load : instr_store;
          end
        end
        default: iclass = instr_undef;
      endcase
    end
  end

  // Condition check against NZCV
  always_comb begin
    case (cond)
      cond_eq: cond_pass = z;
      cond_ne: cond_pass = !z;
      cond_cs: cond_pass = c;
      cond_cc: cond_pass = !c;
      cond_mi: cond_pass = n;
      cond_pl: cond_pass = !n;
      cond_vs: cond_pass = v;
      cond_vc: cond_pass = !v;
      cond_hi: cond_pass = c && !z;
      cond_ls: cond_pass = !c || z;
      cond_ge: cond_pass = (n == v);
      cond_lt: cond_pass = (n != v);
      cond_gt: cond_pass = !z && (n == v);
      cond_le: cond_pass = z || (n != v);
      cond_al: cond_pass = 1'b1;
      default: cond_pass = 1'b0;
    endcase
  end

  always_comb begin
    decoded.ir        = ir;
    decoded.iclass    = iclass;
    decoded.cond_pass = cond_pass;
    decoded.rn        = field.dp_imm.rn;
    decoded.rd        = field.dp_imm.rd;
    decoded.rm        = field.dp_reg_imm.rm;
    decoded.rs        = field.dp_reg_reg.rs;
    decoded.field     = field;
  end

endmodule

`default_nettype wire

// ==== src/control_pkg.sv ====
`default_nettype none

package control_pkg;
  import arm_isa_pkg::*;

  // Flush length after reset, and counter widths
  localparam int reset_flush_len = 3;
  localparam int flush_cnt_w = 2;
  localparam int cycle_cnt_w = 2;

  typedef enum logic [1:0] {
    addr_pc   = 2'd0,
    addr_incr = 2'd1,
    addr_alu  = 2'd2
  } addr_src_t;

  typedef enum logic [2:0] {
    b_imm       = 3'd0,
    b_reg_rm    = 3'd1,
    b_reg_rs    = 3'd2,
    b_reg_rd    = 3'd3,
    b_read_data = 3'd4
  } b_src_t;

  typedef enum logic [1:0] {
    wb_none = 2'd0,
    wb_rd   = 2'd1,
    wb_rn   = 2'd2
  } alu_wb_t;

  // ========================================
  // Datapath control word
  // ========================================

  typedef struct packed {
    logic        pipeline_advance;
    addr_src_t   addr_bus_src;
    logic        memory_read_en;
    logic        memory_write_en;
    logic        memory_byte_transfer;
    logic        memory_latch_ir;
    logic        incrementer_writeback;
    b_src_t      b_bus_source;
    logic [11:0] b_bus_imm;
    shift_t      shift_type;
    logic [4:0]  shift_amount;
    logic        shift_latch_amt;
    logic        shift_use_latch;
    logic        shift_use_rrx;
    alu_op_t     alu_op;
    alu_wb_t     alu_writeback;
    logic        alu_set_flags;
    logic        alu_latch_op_b;
    logic        alu_disable_op_b;
    logic        alu_use_op_b_latch;
  } control_t;

  // Compare and test opcodes only update flags
  function automatic alu_wb_t alu_writeback_for(alu_op_t op);
    case (op)
      alu_tst, alu_teq, alu_cmp, alu_cmn: return wb_none;
      default: return wb_rd;
    endcase
  endfunction

endpackage

`default_nettype wire

// ==== src/arm_isa_pkg.sv ====
`default_nettype none

package arm_isa_pkg;

  // ========================================
  // Instruction classes and field encodings
  // ========================================

  typedef enum logic [2:0] {
    instr_dataproc_imm     = 3'd0,
    instr_dataproc_reg_imm = 3'd1,
    instr_dataproc_reg_reg = 3'd2,
    instr_load             = 3'd3,
    instr_store            = 3'd4,
    instr_undef            = 3'd5
  } instr_class_t;

  // Condition field, bits 31:28
  typedef enum logic [3:0] {
    cond_eq, cond_ne, cond_cs, cond_cc,
    cond_mi, cond_pl, cond_vs, cond_vc,
    cond_hi, cond_ls, cond_ge, cond_lt,
    cond_gt, cond_le, cond_al, cond_nv
  } cond_t;

  typedef enum logic [1:0] {
    shift_lsl = 2'd0,
    shift_lsr = 2'd1,
    shift_asr = 2'd2,
    shift_ror = 2'd3
  } shift_t;

  // Data-processing opcode, bits 24:21
  typedef enum logic [3:0] {
    alu_and, alu_eor, alu_sub, alu_rsb,
    alu_add, alu_adc, alu_sbc, alu_rsc,
    alu_tst, alu_teq, alu_cmp, alu_cmn,
    alu_orr, alu_mov, alu_bic, alu_mvn
  } alu_op_t;

  // ========================================
  // Operand field views, bits 24:0
  // ========================================

  typedef struct packed {
    alu_op_t    opcode;
    logic       set_flags;
    logic [3:0] rn;
    logic [3:0] rd;
    logic [3:0] rotate;
    logic [7:0] imm8;
  } dp_imm_t;

  // Also the shifted-register offset of a load or store
  typedef struct packed {
    alu_op_t    opcode;
    logic       set_flags;
    logic [3:0] rn;
    logic [3:0] rd;
    logic [4:0] shift_amount;
    shift_t     shift_type;
    logic       reg_shift;
    logic [3:0] rm;
  } dp_reg_imm_t;

  typedef struct packed {
    alu_op_t    opcode;
    logic       set_flags;
    logic [3:0] rn;
    logic [3:0] rd;
    logic [3:0] rs;
    logic       bit7;
    shift_t     shift_type;
    logic       reg_shift;
    logic [3:0] rm;
  } dp_reg_reg_t;

  typedef struct packed {
    logic        p;
    logic        u;
    logic        b;
    logic        w;
    logic        l;
    logic [3:0]  rn;
    logic [3:0]  rd;
    logic [11:0] offset;
  } ls_fields_t;

  typedef union packed {
    dp_imm_t     dp_imm;
    dp_reg_imm_t dp_reg_imm;
    dp_reg_reg_t dp_reg_reg;
    ls_fields_t  ls;
  } operand_field_u;

  typedef struct packed {
    logic [31:0]    ir;
    instr_class_t   iclass;
    logic           cond_pass;
    logic [3:0]     rn;
    logic [3:0]     rd;
    logic [3:0]     rm;
    logic [3:0]     rs;
    operand_field_u field;
  } decoded_instr_t;

endpackage

`default_nettype wire
